//--- tb/cpu_tests.txt
# P addr b0..b7 : program bytes | D addr byte : data byte
# W addr en data : expected store in order | E : end
P 4000 10 3C 11 25 22 00 02 12
P 4008 70 22 01 02 13 0F 22 02
P 4010 02 14 A0 22 03 02 15 FF
P 4018 22 04 02 21 00 01 20 01
P 4020 01 22 05 02 25 CD AB 24
P 4028 06 02 23 10 01 02 24 08
P 4030 02 10 01 12 01 31 07 10
P 4038 E1 22 10 02 10 A1 22 10
P 4040 02 11 00 32 07 10 E2 22
P 4048 11 02 10 A2 22 11 02 13
P 4050 FF 33 07 10 B3 22 12 02
P 4058 10 A3 22 12 02 11 F0 33
P 4060 07 10 E4 22 13 02 10 A4
P 4068 22 13 02 13 7F 34 07 10
P 4070 B5 22 14 02 10 A5 22 14
P 4078 02 14 00 31 07 10 B6 22
P 4080 15 02 10 A6 22 15 02 15
P 4088 00 34 07 10 E7 22 16 02
P 4090 10 A7 22 16 02 12 A7 32
P 4098 07 10 B8 22 17 02 10 A8
P 40A0 22 17 02 26 B0 40 10 E9
P 40A8 22 18 02 00 00 00 00 00
P 40B0 10 A9 22 18 02 30 07 10
P 40B8 EA 22 19 02 10 AA 22 19
P 40C0 02 01 00 00 00 00 00 00
D 0100 7A
D 0101 93
D 0110 34
D 0111 12
W 0200 01 0061
W 0201 01 00F1
W 0202 01 0001
W 0203 01 00A1
W 0204 01 005E
W 0205 01 000D
W 0206 11 ABCD
W 0208 11 1241
W 0210 01 00A1
W 0211 01 00A2
W 0212 01 00B3
W 0212 01 00A3
W 0213 01 00A4
W 0214 01 00B5
W 0214 01 00A5
W 0215 01 00B6
W 0215 01 00A6
W 0216 01 00A7
W 0217 01 00B8
W 0217 01 00A8
W 0218 01 00A9
W 0219 01 00AA
E

//--- verilog.f
hdl/isa_pkg.sv
hdl/core_pkg.sv
hdl/fetch_unit.sv
hdl/decoder.sv
hdl/alu.sv
hdl/regfile.sv
hdl/mem_port.sv
hdl/cpu.sv
tb/cpu_properties.sv
tb/cpu_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --assert --top-module cpu_tb -f verilog.f -o cpu_sim
out=$(./obj_dir/cpu_sim)
echo "$out"
echo "$out" | grep -q "RESULT: PASS"

//--- tb/cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb;

	localparam core_pkg::addr_t RESET_PC = 16'h4000;

	logic clk;
	logic reset;
	core_pkg::addr_t iread_addr;
	core_pkg::inst_t iread_data;
	core_pkg::addr_t dread_addr;
	core_pkg::word_t dread_data;
	core_pkg::addr_t dwrite_addr;
	core_pkg::word_t dwrite_data;
	core_pkg::byte_en_t dwrite_en;
	logic trap;

	logic [7:0] imem [0:65535];
	logic [7:0] dmem [0:65535];

	// port values latched mid-cycle for the memory models
	core_pkg::addr_t ia_q;
	core_pkg::addr_t da_q;
	core_pkg::addr_t wa_q;
	core_pkg::word_t wd_q;
	core_pkg::byte_en_t we_q;

	core_pkg::addr_t exp_addr [$];
	core_pkg::byte_en_t exp_en [$];
	core_pkg::word_t exp_data [$];

	int errors;
	int checks;
	int prog_bytes;
	int wr_count;
	int trap_count;
	logic loaded;

	cpu #(
		.RESET_PC(RESET_PC)
	) dut0 (
		.clk(clk),
		.reset(reset),
		.iread_addr(iread_addr),
		.iread_data(iread_data),
		.dread_addr(dread_addr),
		.dread_data(dread_data),
		.dwrite_addr(dwrite_addr),
		.dwrite_data(dwrite_data),
		.dwrite_en(dwrite_en),
		.trap(trap)
	);

	always #5 clk = ~clk;

	task automatic check(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		if (actual !== expected)
		begin
			$display("FAILED %0t %s: expected %h, got %h", $time, name, expected, actual);
			errors++;
		end
	endtask

	task automatic load_tests();
		int fd;
		int r;
		string line;
		logic [15:0] addr;
		logic [7:0] b [8];
		logic [1:0] en;
		logic [15:0] data;
		fd = $fopen("tb/cpu_tests.txt", "r");
		if (fd == 0)
		begin
			$display("could not open tb/cpu_tests.txt");
			errors++;
		end
		else
		begin
			while (!$feof(fd))
			begin
				line = "";
				r = $fgets(line, fd);
				if (line.len() == 0)
					continue;
				case (line.getc(0))
					"P":
					begin
						r = $sscanf(line, "P %h %h %h %h %h %h %h %h %h", addr,
							b[0], b[1], b[2], b[3], b[4], b[5], b[6], b[7]);
						for (int i = 0; i < 8; i++)
							imem[16'(addr + 16'(i))] = b[i];
						prog_bytes += 8;
					end
					"D":
					begin
						r = $sscanf(line, "D %h %h", addr, b[0]);
						dmem[addr] = b[0];
					end
					"W":
					begin
						r = $sscanf(line, "W %h %b %h", addr, en, data);
						exp_addr.push_back(addr);
						exp_en.push_back(en);
						exp_data.push_back(data);
					end
					"E":
						break;
					default:
						;
				endcase
			end
			$fclose(fd);
		end
	endtask

	task automatic check_reset_outputs();
		check("iread_addr", 32'(RESET_PC), 32'(iread_addr));
		check("dwrite_en", 32'(2'b00), 32'(dwrite_en));
		check("trap", 32'(1'b0), 32'(trap));
	endtask

	// write-first registered memories answer 1 ns after the edge
	always @(negedge clk)
	begin
		ia_q = iread_addr;
		da_q = dread_addr;
		wa_q = dwrite_addr;
		wd_q = dwrite_data;
		we_q = dwrite_en;
	end

	always @(posedge clk)
	begin
		#1;
		if (we_q[0])
			dmem[wa_q] = wd_q[7:0];
		if (we_q[1])
			dmem[16'(wa_q + 16'd1)] = wd_q[15:8];
		iread_data = {imem[16'(ia_q + 16'd2)], imem[16'(ia_q + 16'd1)], imem[ia_q]};
		dread_data = {dmem[16'(da_q + 16'd1)], dmem[da_q]};
	end

	// compare each store against the expected list in order
	always @(negedge clk)
	begin
		if (!reset && dwrite_en != 2'b00)
		begin
			if (wr_count >= exp_addr.size())
			begin
				$display("unexpected extra write to %h at %0t", dwrite_addr, $time);
				errors++;
			end
			else
			begin
				check("dwrite_addr", 32'(exp_addr[wr_count]), 32'(dwrite_addr));
				check("dwrite_en", 32'(exp_en[wr_count]), 32'(dwrite_en));
				check("dwrite_data",
					32'(exp_data[wr_count] & {{8{exp_en[wr_count][1]}}, {8{exp_en[wr_count][0]}}}),
					32'(dwrite_data & {{8{dwrite_en[1]}}, {8{dwrite_en[0]}}}));
			end
			wr_count++;
		end
		if (!reset && trap)
			trap_count++;
	end

	initial
	begin
		int limit;
		wait (loaded);
		limit = prog_bytes * 10 + 200;
		repeat (limit) @(posedge clk);
		$display("timeout: the trap never came within %0d cycles", limit);
		$display("RESULT: FAIL");
		$finish;
	end

	initial
	begin
		clk = 1'b0;
		reset = 1'b1;
		iread_data = '0;
		dread_data = '0;
		ia_q = '0;
		da_q = '0;
		wa_q = '0;
		wd_q = '0;
		we_q = '0;
		errors = 0;
		checks = 0;
		prog_bytes = 0;
		wr_count = 0;
		trap_count = 0;
		loaded = 1'b0;
		for (int i = 0; i < 65536; i++)
		begin
			imem[i] = 8'h00;
			dmem[i] = 8'h00;
		end
		load_tests();
		loaded = 1'b1;

		repeat (10)
		begin
			@(negedge clk);
			check_reset_outputs();
		end
		@(posedge clk);
		#1 reset = 1'b0;
		// still fetching RESET_PC in the first cycle out of reset
		@(negedge clk);
		check_reset_outputs();

		while (trap_count == 0)
			@(negedge clk);
		repeat (4) @(negedge clk);
		check("trap_count", 32'd1, 32'(trap_count));
		check("write_count", 32'(exp_addr.size()), 32'(wr_count));

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

//--- tb/cpu_properties.sv
`timescale 1ns/1ps

module cpu_properties (
	input logic       clk,
	input logic       reset,
	input logic [1:0] dwrite_en,
	input logic       trap
);

	// a lone high byte is never stored
	no_high_only: assert property (@(posedge clk) dwrite_en != 2'b10)
		else $error("dwrite_en showed only the high byte");

	quiet_in_reset: assert property (@(posedge clk) reset |-> dwrite_en == 2'b00)
		else $error("dwrite_en active during reset");

	trap_single: assert property (@(posedge clk) disable iff (reset) trap |=> !trap)
		else $error("trap stayed high for two cycles");

endmodule

bind cpu cpu_properties props0 (
	.clk(clk),
	.reset(reset),
	.dwrite_en(dwrite_en),
	.trap(trap)
);

//--- hdl/cpu.sv
`timescale 1ns/1ps

module cpu #(
	parameter core_pkg::addr_t RESET_PC = 16'h4000
) (
	input  logic               clk,
	input  logic               reset,
	output core_pkg::addr_t    iread_addr,
	input  core_pkg::inst_t    iread_data,
	output core_pkg::addr_t    dread_addr,
	input  core_pkg::word_t    dread_data,
	output core_pkg::addr_t    dwrite_addr,
	output core_pkg::word_t    dwrite_data,
	output core_pkg::byte_en_t dwrite_en,
	output logic               trap
);

	core_pkg::inst_t inst;
	core_pkg::inst_t next_inst;
	isa_pkg::alu_op_t alu_op;
	core_pkg::opsel_t opa_sel;
	core_pkg::opsel_t opb_sel;
	core_pkg::reg_idx_t reg_idx;
	core_pkg::byte_en_t reg_we;
	logic flag_we;
	core_pkg::byte_en_t mem_we;
	core_pkg::reg_idx_t mem_src;
	logic is_trap;
	core_pkg::word_t x;
	core_pkg::word_t y;
	core_pkg::word_t imm;
	core_pkg::word_t opa;
	core_pkg::word_t opb;
	core_pkg::word_t result;
	logic alu_c;
	logic alu_z;
	logic alu_n;
	isa_pkg::flags_t alu_flags;
	isa_pkg::flags_t next_flags;

	fetch_unit #(
		.RESET_PC(RESET_PC)
	) fetch0 (
		.clk(clk),
		.reset(reset),
		.iread_data(iread_data),
		.next_flags(next_flags),
		.iread_addr(iread_addr),
		.inst(inst),
		.next_inst(next_inst)
	);

	decoder dec0 (
		.inst(inst),
		.alu_op(alu_op),
		.opa_sel(opa_sel),
		.opb_sel(opb_sel),
		.reg_idx(reg_idx),
		.reg_we(reg_we),
		.flag_we(flag_we),
		.mem_we(mem_we),
		.mem_src(mem_src),
		.is_trap(is_trap)
	);

	assign imm = inst[23:8];

	// a takes the destination register, b only ever needs x
	always_comb
	begin
		case (opa_sel)
			core_pkg::OPSEL_MEM:
				opa = dread_data;
			core_pkg::OPSEL_IMM:
				opa = imm;
			default:
				opa = (reg_idx == core_pkg::REG_Y) ? y : x;
		endcase
		case (opb_sel)
			core_pkg::OPSEL_MEM:
				opb = dread_data;
			core_pkg::OPSEL_IMM:
				opb = imm;
			default:
				opb = x;
		endcase
	end

	alu alu0 (
		.op(alu_op),
		.a(opa),
		.b(opb),
		.result(result),
		.c(alu_c),
		.z(alu_z),
		.n(alu_n)
	);

	always_comb
	begin
		alu_flags = '0;
		alu_flags[isa_pkg::FLAG_C] = alu_c;
		alu_flags[isa_pkg::FLAG_Z] = alu_z;
		alu_flags[isa_pkg::FLAG_N] = alu_n;
	end

	regfile rf0 (
		.clk(clk),
		.reset(reset),
		.reg_idx(reg_idx),
		.reg_we(reg_we),
		.wdata(result),
		.flag_we(flag_we),
		.alu_flags(alu_flags),
		.x(x),
		.y(y),
		.flags(),
		.next_flags(next_flags)
	);

	mem_port mport0 (
		.clk(clk),
		.reset(reset),
		.inst(inst),
		.next_inst(next_inst),
		.mem_we(mem_we),
		.mem_src(mem_src),
		.x(x),
		.y(y),
		.is_trap(is_trap),
		.dread_addr(dread_addr),
		.dwrite_addr(dwrite_addr),
		.dwrite_data(dwrite_data),
		.dwrite_en(dwrite_en),
		.trap(trap)
	);

endmodule

//--- hdl/mem_port.sv
`timescale 1ns/1ps

module mem_port (
	input  logic               clk,
	input  logic               reset,
	input  core_pkg::inst_t    inst,
	input  core_pkg::inst_t    next_inst,
	input  core_pkg::byte_en_t mem_we,
	input  core_pkg::reg_idx_t mem_src,
	input  core_pkg::word_t    x,
	input  core_pkg::word_t    y,
	input  logic               is_trap,
	output core_pkg::addr_t    dread_addr,
	output core_pkg::addr_t    dwrite_addr,
	output core_pkg::word_t    dwrite_data,
	output core_pkg::byte_en_t dwrite_en,
	output logic               trap
);

	// issued one cycle early so the data lines up with execute
	assign dread_addr = next_inst[23:8];

	assign dwrite_addr = inst[23:8];
	assign dwrite_data = (mem_src == core_pkg::REG_Y) ? y : x;
	assign dwrite_en = reset ? 2'b00 : mem_we;

	always_ff @(posedge clk)
	begin
		if (reset)
			trap <= 1'b0;
		else
			trap <= is_trap;
	end

endmodule

//--- hdl/regfile.sv
`timescale 1ns/1ps

module regfile (
	input  logic               clk,
	input  logic               reset,
	input  core_pkg::reg_idx_t reg_idx,
	input  core_pkg::byte_en_t reg_we,
	input  core_pkg::word_t    wdata,
	input  logic               flag_we,
	input  isa_pkg::flags_t    alu_flags,
	output core_pkg::word_t    x,
	output core_pkg::word_t    y,
	output isa_pkg::flags_t    flags,
	output isa_pkg::flags_t    next_flags
);

	// flags as they will be after this edge
	assign next_flags = flag_we ? alu_flags : flags;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			x <= '0;
			y <= '0;
			flags <= '0;
		end
		else
		begin
			if (reg_we[0])
			begin
				if (reg_idx == core_pkg::REG_Y)
					y[7:0] <= wdata[7:0];
				else
					x[7:0] <= wdata[7:0];
			end
			if (reg_we[1])
			begin
				if (reg_idx == core_pkg::REG_Y)
					y[15:8] <= wdata[15:8];
				else
					x[15:8] <= wdata[15:8];
			end
			flags <= next_flags;
		end
	end

endmodule

//--- hdl/alu.sv
`timescale 1ns/1ps

module alu (
	input  isa_pkg::alu_op_t op,
	input  core_pkg::word_t  a,
	input  core_pkg::word_t  b,
	output core_pkg::word_t  result,
	output logic             c,
	output logic             z,
	output logic             n
);

	logic [8:0] r9;
	logic [16:0] r17;
	logic wide;
	core_pkg::byte_t res_lo;

	always_comb
	begin
		r9 = '0;
		r17 = '0;
		wide = 1'b0;
		c = 1'b0;
		case (op)
			isa_pkg::PASSW:
			begin
				r17 = {1'b0, a};
				wide = 1'b1;
			end
			isa_pkg::ADD:
			begin
				r9 = {1'b0, a[7:0]} + {1'b0, b[7:0]};
				c = r9[8];
			end
			// borrow out of bit 7
			isa_pkg::SUB:
			begin
				r9 = {1'b0, a[7:0]} - {1'b0, b[7:0]};
				c = r9[8];
			end
			isa_pkg::AND:
				r9 = {1'b0, a[7:0] & b[7:0]};
			isa_pkg::OR:
				r9 = {1'b0, a[7:0] | b[7:0]};
			isa_pkg::XOR:
				r9 = {1'b0, a[7:0] ^ b[7:0]};
			isa_pkg::ADDW:
			begin
				r17 = {1'b0, a} + {1'b0, b};
				c = r17[16];
				wide = 1'b1;
			end
			default:
				r9 = {1'b0, a[7:0]};
		endcase
	end

	assign res_lo = r9[7:0];
	// byte ops keep the high byte of a
	assign result = wide ? r17[15:0] : {a[15:8], res_lo};
	assign z = wide ? (result == 16'h0000) : (res_lo == 8'h00);
	assign n = wide ? result[15] : res_lo[7];

endmodule

//--- hdl/decoder.sv
`timescale 1ns/1ps

module decoder (
	input  core_pkg::inst_t    inst,
	output isa_pkg::alu_op_t   alu_op,
	output core_pkg::opsel_t   opa_sel,
	output core_pkg::opsel_t   opb_sel,
	output core_pkg::reg_idx_t reg_idx,
	output core_pkg::byte_en_t reg_we,
	output logic               flag_we,
	output core_pkg::byte_en_t mem_we,
	output core_pkg::reg_idx_t mem_src,
	output logic               is_trap
);

	isa_pkg::opcode_t opcode;

	assign opcode = isa_pkg::opcode_t'(inst[7:0]);

	always_comb
	begin
		case (opcode)
			isa_pkg::LDW_Y_IMMD, isa_pkg::LDW_Y_DIR:
				alu_op = isa_pkg::PASSW;
			isa_pkg::ADD_XL_IMMD, isa_pkg::ADD_XL_DIR:
				alu_op = isa_pkg::ADD;
			isa_pkg::SUB_XL_IMMD:
				alu_op = isa_pkg::SUB;
			isa_pkg::AND_XL_IMMD:
				alu_op = isa_pkg::AND;
			isa_pkg::OR_XL_IMMD:
				alu_op = isa_pkg::OR;
			isa_pkg::XOR_XL_IMMD:
				alu_op = isa_pkg::XOR;
			isa_pkg::ADDW_Y_X:
				alu_op = isa_pkg::ADDW;
			default:
				alu_op = isa_pkg::PASS;
		endcase
	end

	always_comb
	begin
		opa_sel = core_pkg::OPSEL_REG;
		opb_sel = core_pkg::OPSEL_IMM;
		reg_idx = core_pkg::REG_X;
		reg_we = 2'b00;
		flag_we = 1'b0;
		mem_we = 2'b00;
		mem_src = core_pkg::REG_X;
		is_trap = 1'b0;
		case (opcode)
			isa_pkg::LD_XL_IMMD:
			begin
				opa_sel = core_pkg::OPSEL_IMM;
				reg_we = 2'b01;
			end
			isa_pkg::LDW_Y_IMMD:
			begin
				opa_sel = core_pkg::OPSEL_IMM;
				reg_idx = core_pkg::REG_Y;
				reg_we = 2'b11;
			end
			isa_pkg::ADD_XL_IMMD, isa_pkg::SUB_XL_IMMD, isa_pkg::AND_XL_IMMD,
			isa_pkg::OR_XL_IMMD, isa_pkg::XOR_XL_IMMD:
			begin
				reg_we = 2'b01;
				flag_we = 1'b1;
			end
			isa_pkg::ADD_XL_DIR:
			begin
				opb_sel = core_pkg::OPSEL_MEM;
				reg_we = 2'b01;
				flag_we = 1'b1;
			end
			isa_pkg::LD_XL_DIR:
			begin
				opa_sel = core_pkg::OPSEL_MEM;
				reg_we = 2'b01;
			end
			isa_pkg::LDW_Y_DIR:
			begin
				opa_sel = core_pkg::OPSEL_MEM;
				reg_idx = core_pkg::REG_Y;
				reg_we = 2'b11;
			end
			isa_pkg::LD_DIR_XL:
				mem_we = 2'b01;
			isa_pkg::LDW_DIR_Y:
			begin
				mem_we = 2'b11;
				mem_src = core_pkg::REG_Y;
			end
			isa_pkg::ADDW_Y_X:
			begin
				opb_sel = core_pkg::OPSEL_REG;
				reg_idx = core_pkg::REG_Y;
				reg_we = 2'b11;
				flag_we = 1'b1;
			end
			isa_pkg::TRAP:
				is_trap = 1'b1;
			// jumps are handled in fetch, nothing to write here
			default:
				;
		endcase
	end

endmodule

//--- hdl/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit #(
	parameter core_pkg::addr_t RESET_PC = 16'h4000
) (
	input  logic            clk,
	input  logic            reset,
	input  core_pkg::inst_t iread_data,
	input  isa_pkg::flags_t next_flags,
	output core_pkg::addr_t iread_addr,
	output core_pkg::inst_t inst,
	output core_pkg::inst_t next_inst
);

	localparam core_pkg::inst_t NOP_INST = {16'h0000, isa_pkg::NOP};

	core_pkg::addr_t pc;
	core_pkg::addr_t next_pc;
	core_pkg::addr_t rel_target;
	isa_pkg::opcode_t next_op;
	logic running;
	logic jump_rel;

	// iread_data is not valid until RESET_PC has been fetched once
	assign next_inst = running ? iread_data : NOP_INST;
	assign next_op = isa_pkg::opcode_t'(next_inst[7:0]);
	assign rel_target = pc + {{8{next_inst[15]}}, next_inst[15:8]};

	// conditions see the flags written by the executing instruction
	always_comb
	begin
		case (next_op)
			isa_pkg::JR_D:
				jump_rel = 1'b1;
			isa_pkg::JRZ_D:
				jump_rel = next_flags[isa_pkg::FLAG_Z];
			isa_pkg::JRNZ_D:
				jump_rel = !next_flags[isa_pkg::FLAG_Z];
			isa_pkg::JRC_D:
				jump_rel = next_flags[isa_pkg::FLAG_C];
			isa_pkg::JRN_D:
				jump_rel = next_flags[isa_pkg::FLAG_N];
			default:
				jump_rel = 1'b0;
		endcase
	end

	always_comb
	begin
		if (reset || !running)
			next_pc = RESET_PC;
		else if (next_op == isa_pkg::JP_IMMD)
			next_pc = next_inst[23:8];
		else if (jump_rel)
			next_pc = rel_target;
		else
			next_pc = pc + core_pkg::addr_t'(isa_pkg::inst_len(next_op));
	end

	assign iread_addr = next_pc;

	always_ff @(posedge clk)
	begin
		pc <= next_pc;
		if (reset)
		begin
			running <= 1'b0;
			inst <= NOP_INST;
		end
		else
		begin
			running <= 1'b1;
			inst <= next_inst;
		end
	end

endmodule

//--- hdl/core_pkg.sv
package core_pkg;

	typedef logic [15:0] word_t;
	typedef logic [7:0] byte_t;
	typedef logic [15:0] addr_t;
	// opcode in [7:0], operand little-endian in [23:8]
	typedef logic [23:0] inst_t;
	typedef logic [1:0] byte_en_t;
	typedef logic reg_idx_t;

	localparam reg_idx_t REG_X = 1'b0;
	localparam reg_idx_t REG_Y = 1'b1;

	typedef enum logic [1:0] {
		OPSEL_REG,
		OPSEL_MEM,
		OPSEL_IMM
	} opsel_t;

endpackage

//--- hdl/isa_pkg.sv
package isa_pkg;

	typedef logic [2:0] flags_t;

	localparam int FLAG_C = 0;
	localparam int FLAG_Z = 1;
	localparam int FLAG_N = 2;

	typedef enum logic [7:0] {
		NOP         = 8'h00,
		TRAP        = 8'h01,
		ADDW_Y_X    = 8'h02,
		LD_XL_IMMD  = 8'h10,
		ADD_XL_IMMD = 8'h11,
		SUB_XL_IMMD = 8'h12,
		AND_XL_IMMD = 8'h13,
		OR_XL_IMMD  = 8'h14,
		XOR_XL_IMMD = 8'h15,
		ADD_XL_DIR  = 8'h20,
		LD_XL_DIR   = 8'h21,
		LD_DIR_XL   = 8'h22,
		LDW_Y_DIR   = 8'h23,
		LDW_DIR_Y   = 8'h24,
		LDW_Y_IMMD  = 8'h25,
		JP_IMMD     = 8'h26,
		JR_D        = 8'h30,
		JRZ_D       = 8'h31,
		JRNZ_D      = 8'h32,
		JRC_D       = 8'h33,
		JRN_D       = 8'h34
	} opcode_t;

	typedef enum logic [2:0] {
		PASS,
		PASSW,
		ADD,
		SUB,
		AND,
		OR,
		XOR,
		ADDW
	} alu_op_t;

	// bytes per instruction, opcode included
	function automatic logic [1:0] inst_len(opcode_t op);
		case (op)
			LDW_Y_IMMD, ADD_XL_DIR, LD_XL_DIR, LD_DIR_XL, LDW_Y_DIR, LDW_DIR_Y, JP_IMMD:
				inst_len = 2'd3;
			LD_XL_IMMD, ADD_XL_IMMD, SUB_XL_IMMD, AND_XL_IMMD, OR_XL_IMMD, XOR_XL_IMMD,
			JR_D, JRZ_D, JRNZ_D, JRC_D, JRN_D:
				inst_len = 2'd2;
			default:
				inst_len = 2'd1;
		endcase
	endfunction

endpackage
